/* src/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int WAYS       = 4;
    localparam int SETS       = 128;
    localparam int LINE_WORDS = 8;   // also beats per burst
    localparam int ADDR_W     = 32;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 5;
    localparam int TAG_W      = 20;
    localparam int BURST_LEN  = LINE_WORDS - 1;   // axi len field value

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [31:0]               word_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-3:0]       word_idx_t;
    typedef logic [$clog2(WAYS)-1:0]   way_t;
    typedef logic [WAYS-1:0]           way_mask_t;
    typedef logic [3:0]                wstrb_t;
    typedef logic [WAYS-2:0]           plru_t;

    localparam wstrb_t FULL_STRB = 4'hf;   // refill beats write whole words

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        REPLAY
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic word_idx_t addr_word(addr_t a);
        return a[OFFSET_W-1:2];
    endfunction

    // byte offset forced to zero
    function automatic addr_t line_addr(tag_t t, index_t i);
        return {t, i, {OFFSET_W{1'b0}}};
    endfunction

endpackage

/* src/dcache_data_store.sv */
module dcache_data_store import dcache_pkg::*; (
    input  logic      clk,

    // read port
    input  logic      rd_en,
    input  index_t    rd_index,
    input  tag_t      lookup_tag,
    input  way_mask_t valid_mask,
    input  way_t      sel_way,
    input  word_idx_t sel_idx,
    input  way_t      victim_way,

    // write port
    input  logic      wr_en,
    input  way_t      wr_way,
    input  word_idx_t wr_idx,
    input  wstrb_t    wr_be,
    input  word_t     wr_data,
    input  logic      tag_we,
    input  index_t    wr_index,

    output logic      hit,
    output way_t      hit_way,
    output word_t     sel_word,
    output tag_t      victim_tag
);

    tag_t  tag_mem  [WAYS][SETS];
    word_t data_mem [WAYS][LINE_WORDS][SETS];

    tag_t  tag_q  [WAYS];               // registered read
    word_t line_q [WAYS][LINE_WORDS];

    way_mask_t hit_vec;

    // tag array
    always_ff @(posedge clk) begin
        if (tag_we)
            tag_mem[wr_way][wr_index] <= lookup_tag;
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++)
                tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    // data array, byte lanes written separately
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b])
                    data_mem[wr_way][wr_idx][wr_index][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int k = 0; k < LINE_WORDS; k++)
                    line_q[w][k] <= data_mem[w][k][rd_index];
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_mask[w] && (tag_q[w] == lookup_tag);
            if (hit_vec[w])
                hit_way = way_t'(w);
        end
    end

    assign hit = |hit_vec;

    assign sel_word   = line_q[sel_way][sel_idx];
    assign victim_tag = tag_q[victim_way];   // write-back address

endmodule

/* src/dcache_line_state.sv */
module dcache_line_state import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  index_t    index,
    input  logic      touch,
    input  way_t      touch_way,
    input  logic      fill,
    input  logic      mark_dirty,
    output way_mask_t valid_mask,
    output way_t      victim_way,
    output logic      victim_dirty
);

    way_mask_t valid_q [SETS];
    way_mask_t dirty_q [SETS];
    plru_t     plru_q  [SETS];

    plru_t     plru;

    assign plru       = plru_q[index];
    assign valid_mask = valid_q[index];

    // tree walk: bit0 picks the half, bit1 or bit2 the way inside it
    assign victim_way = {plru[0], plru[0] ? plru[2] : plru[1]};

    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (touch) begin
                plru_q[index][0] <= ~touch_way[1];   // point away from this half
                if (touch_way[1])
                    plru_q[index][2] <= ~touch_way[0];
                else
                    plru_q[index][1] <= ~touch_way[0];
            end

            // new line arrives clean
            if (fill) begin
                valid_q[index][victim_way] <= 1'b1;
                dirty_q[index][victim_way] <= 1'b0;
            end

            if (mark_dirty)
                dirty_q[index][touch_way] <= 1'b1;
        end
    end

endmodule

/* src/dcache_ctrl.sv */
module dcache_ctrl import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // datapath
    input  logic      data_en,
    input  addr_t     data_addr,
    input  wstrb_t    data_wen,
    input  word_t     data_wdata,

    // from data store and line state
    input  logic      hit,
    input  way_t      hit_way,
    input  word_t     sel_word,
    input  tag_t      victim_tag,
    input  way_t      victim_way,
    input  logic      victim_dirty,

    // axi inputs
    input  logic      arready,
    input  word_t     rdata,
    input  logic      rlast,
    input  logic      rvalid,
    input  logic      awready,
    input  logic      wready,
    input  logic      bvalid,

    output word_t     data_rdata,
    output logic      stall,

    // array controls
    output logic      rd_en,
    output index_t    rd_index,
    output way_t      sel_way,
    output word_idx_t sel_idx,
    output logic      wr_en,
    output way_t      wr_way,
    output word_idx_t wr_idx,
    output wstrb_t    wr_be,
    output word_t     wr_data,
    output logic      tag_we,

    // line state updates
    output logic      touch,
    output way_t      touch_way,
    output logic      fill,
    output logic      mark_dirty,

    // axi outputs
    output addr_t     araddr,
    output logic      arvalid,
    output logic      rready,
    output addr_t     awaddr,
    output logic      awvalid,
    output word_t     wdata,
    output logic      wlast,
    output logic      wvalid,
    output logic      bready
);

    ctrl_state_t state, state_next;

    word_idx_t rf_cnt;    // refill beat
    word_idx_t wb_cnt;    // write-back beat
    logic      ar_done;
    logic      aw_done;
    logic      w_done;

    logic      lookup_hit;
    logic      store;
    logic      r_beat;
    logic      w_beat;
    logic      refill_end;
    logic      wb_end;

    assign store      = |data_wen;
    assign lookup_hit = (state == LOOKUP) && hit;
    assign r_beat     = rvalid && rready;
    assign w_beat     = wvalid && wready;
    assign refill_end = r_beat && rlast;
    assign wb_end     = bvalid && bready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (data_en) state_next = LOOKUP;
            LOOKUP: begin
                if (hit)
                    state_next = IDLE;
                else if (victim_dirty)
                    state_next = WRITE_BACK;
                else
                    state_next = REFILL;
            end
            WRITE_BACK: if (wb_end) state_next = REFILL;
            REFILL:     if (refill_end) state_next = REPLAY;
            REPLAY:     state_next = LOOKUP;   // re-read the filled line
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            rf_cnt  <= '0;
            wb_cnt  <= '0;
            ar_done <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;

            if (refill_end) begin
                rf_cnt  <= '0;
                ar_done <= 1'b0;
            end else begin
                if (r_beat) rf_cnt <= rf_cnt + 1'b1;
                if (arvalid && arready) ar_done <= 1'b1;
            end

            if (wb_end) begin
                wb_cnt  <= '0;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (w_beat) wb_cnt <= wb_cnt + 1'b1;
                if (awvalid && awready) aw_done <= 1'b1;
                if (w_beat && wlast) w_done <= 1'b1;
            end
        end
    end

    // stall drops only in the cycle a lookup hits
    assign stall      = data_en && !lookup_hit;
    assign data_rdata = sel_word;

    assign rd_en    = ((state == IDLE) && data_en) || (state == REPLAY);
    assign rd_index = addr_index(data_addr);

    // write-back streams the victim line, otherwise the addressed word
    assign sel_way = (state == WRITE_BACK) ? victim_way : hit_way;
    assign sel_idx = (state == WRITE_BACK) ? wb_cnt : addr_word(data_addr);

    always_comb begin
        if (state == REFILL) begin
            wr_en   = r_beat;
            wr_way  = victim_way;
            wr_idx  = rf_cnt;
            wr_be   = FULL_STRB;
            wr_data = rdata;
        end else begin
            wr_en   = lookup_hit && store;
            wr_way  = hit_way;
            wr_idx  = addr_word(data_addr);
            wr_be   = data_wen;
            wr_data = data_wdata;
        end
    end

    assign tag_we     = (state == REFILL) && refill_end;
    assign fill       = tag_we;
    assign touch      = lookup_hit || fill;
    assign touch_way  = (state == REFILL) ? victim_way : hit_way;
    assign mark_dirty = lookup_hit && store;

    // read channel
    assign araddr  = line_addr(addr_tag(data_addr), addr_index(data_addr));
    assign arvalid = (state == REFILL) && !ar_done;
    assign rready  = (state == REFILL) && ar_done;

    // write channel, data only after the address is taken
    assign awaddr  = line_addr(victim_tag, addr_index(data_addr));
    assign awvalid = (state == WRITE_BACK) && !aw_done;
    assign wvalid  = (state == WRITE_BACK) && aw_done && !w_done;
    assign wdata   = sel_word;
    assign wlast   = (wb_cnt == word_idx_t'(BURST_LEN));
    assign bready  = (state == WRITE_BACK) && w_done;

endmodule

/* src/dcache_top.sv */
module dcache_top import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // datapath
    input  logic   data_en,
    input  addr_t  data_addr,
    input  wstrb_t data_wen,
    input  word_t  data_wdata,
    output word_t  data_rdata,
    output logic   stall,

    // axi read
    output addr_t  araddr,
    output logic   arvalid,
    input  logic   arready,
    input  word_t  rdata,
    input  logic   rlast,
    input  logic   rvalid,
    output logic   rready,

    // axi write
    output addr_t  awaddr,
    output logic   awvalid,
    input  logic   awready,
    output word_t  wdata,
    output logic   wlast,
    output logic   wvalid,
    input  logic   wready,
    input  logic   bvalid,
    output logic   bready
);

    logic      hit;
    way_t      hit_way;
    word_t     sel_word;
    tag_t      victim_tag;
    way_t      victim_way;
    logic      victim_dirty;
    way_mask_t valid_mask;

    logic      rd_en;
    index_t    rd_index;   // also the write and line state index
    way_t      sel_way;
    word_idx_t sel_idx;
    logic      wr_en;
    way_t      wr_way;
    word_idx_t wr_idx;
    wstrb_t    wr_be;
    word_t     wr_data;
    logic      tag_we;

    logic      touch;
    way_t      touch_way;
    logic      fill;
    logic      mark_dirty;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .data_en      (data_en),
        .data_addr    (data_addr),
        .data_wen     (data_wen),
        .data_wdata   (data_wdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .sel_word     (sel_word),
        .victim_tag   (victim_tag),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .data_rdata   (data_rdata),
        .stall        (stall),
        .rd_en        (rd_en),
        .rd_index     (rd_index),
        .sel_way      (sel_way),
        .sel_idx      (sel_idx),
        .wr_en        (wr_en),
        .wr_way       (wr_way),
        .wr_idx       (wr_idx),
        .wr_be        (wr_be),
        .wr_data      (wr_data),
        .tag_we       (tag_we),
        .touch        (touch),
        .touch_way    (touch_way),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .rready       (rready),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .wdata        (wdata),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .bready       (bready)
    );

    dcache_line_state u_line_state (
        .clk          (clk),
        .rst          (rst),
        .index        (rd_index),
        .touch        (touch),
        .touch_way    (touch_way),
        .fill         (fill),
        .mark_dirty   (mark_dirty),
        .valid_mask   (valid_mask),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    dcache_data_store u_data_store (
        .clk        (clk),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .lookup_tag (addr_tag(data_addr)),
        .valid_mask (valid_mask),
        .sel_way    (sel_way),
        .sel_idx    (sel_idx),
        .victim_way (victim_way),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_idx     (wr_idx),
        .wr_be      (wr_be),
        .wr_data    (wr_data),
        .tag_we     (tag_we),
        .wr_index   (rd_index),
        .hit        (hit),
        .hit_way    (hit_way),
        .sel_word   (sel_word),
        .victim_tag (victim_tag)
    );

endmodule

/* verif/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // held for 16 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* verif/axi_mem_model.sv */
module axi_mem_model import dcache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output logic  rlast,
    output logic  rvalid,
    input  logic  rready,
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    input  word_t wdata,
    input  logic  wlast,
    input  logic  wvalid,
    output logic  wready,
    output logic  bvalid,
    input  logic  bready
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t       mem [addr_t];   // only written words are stored
    logic [31:0] rng;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a_0000);
    endfunction

    // 0 to 3 idle cycles before a ready or valid
    task automatic ready_delay();
        int d;
        rng = lcg_step(rng);
        d = int'(rng[17:16]);
        repeat (d) @(negedge clk);
    endtask

    task automatic serve_read();
        addr_t base;
        base = araddr;
        ready_delay();
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        for (int k = 0; k <= BURST_LEN; k++) begin
            ready_delay();
            rvalid = 1'b1;
            rdata  = mem_word(base + addr_t'(4 * k));
            rlast  = (k == BURST_LEN);
            do begin
                @(posedge clk);
            end while (!rready);
            @(negedge clk);
            rvalid = 1'b0;
            rlast  = 1'b0;
        end
    endtask

    task automatic serve_write();
        addr_t base;
        word_t beat;
        logic  last;
        int    k;
        base = awaddr;
        k    = 0;
        ready_delay();
        awready = 1'b1;
        @(negedge clk);
        awready = 1'b0;
        do begin
            ready_delay();
            wready = 1'b1;
            do begin
                @(posedge clk);
            end while (!wvalid);
            beat = wdata;   // taken at the handshake edge
            last = wlast;
            @(negedge clk);
            wready = 1'b0;
            mem[base + addr_t'(4 * k)] = beat;
            k++;
        end while (!last);
        ready_delay();
        bvalid = 1'b1;
        do begin
            @(posedge clk);
        end while (!bready);
        @(negedge clk);
        bvalid = 1'b0;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        rng     = 32'h84a4_717e;
        forever begin
            @(negedge clk);
            if (!rst && awvalid)
                serve_write();
            else if (!rst && arvalid)
                serve_read();
        end
    end

endmodule

/* verif/dcache_checker.sv */
module dcache_checker import dcache_pkg::*; (
    input logic        clk,
    input logic        rst,
    input ctrl_state_t state,
    input logic        stall,
    input logic        arvalid,
    input logic        arready,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready
);
    timeunit 1ns;
    timeprecision 100ps;

    // a raised valid waits for its ready
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    // a miss keeps the datapath stalled until the replayed lookup
    miss_stall: assert property (@(posedge clk) disable iff (rst)
        (state != IDLE) && (state != LOOKUP) |-> stall)
        else $error("stall low while a miss is in progress");

endmodule

bind dcache_ctrl dcache_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .state   (state),
    .stall   (stall),
    .arvalid (arvalid),
    .arready (arready),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready)
);

/* verif/dcache_tb.sv */
module dcache_tb import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    ACCESS_COUNT   = 214;   // 2 + 2 + 10 + 200
    localparam int    TIMEOUT_CYCLES = 40 * ACCESS_COUNT + 16;
    localparam word_t INIT_XOR       = 32'h5a5a_0000;

    logic   clk;
    logic   rst;
    logic   data_en;
    addr_t  data_addr;
    wstrb_t data_wen;
    word_t  data_wdata;
    word_t  data_rdata;
    logic   stall;
    addr_t  araddr;
    logic   arvalid, arready;
    word_t  rdata;
    logic   rlast, rvalid, rready;
    addr_t  awaddr;
    logic   awvalid, awready;
    word_t  wdata;
    logic   wlast, wvalid, wready;
    logic   bvalid, bready;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          ar_count = 0;
    int          aw_count = 0;
    int          w_pos = 0;
    addr_t       last_araddr;
    addr_t       last_awaddr;
    word_t       wbeats [$];
    word_t       shadow [addr_t];
    logic [31:0] rng;

    tb_clock u_clock (.clk(clk), .rst(rst));

    axi_mem_model u_mem (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    dcache_top UUT (
        .clk(clk), .rst(rst),
        .data_en(data_en), .data_addr(data_addr), .data_wen(data_wen),
        .data_wdata(data_wdata), .data_rdata(data_rdata), .stall(stall),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wlast(wlast), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ INIT_XOR);
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", what, got, exp, $time);
        end
    endtask

    task automatic update_shadow(input addr_t a, input wstrb_t wen, input word_t wd);
        word_t merged;
        merged = shadow_word(a);
        for (int b = 0; b < 4; b++) begin
            if (wen[b])
                merged[8*b +: 8] = wd[8*b +: 8];
        end
        shadow[a] = merged;
    endtask

    // holds the access until stall is low, lat counts the data_en cycles
    task automatic run_access(input addr_t a, input wstrb_t wen, input word_t wd,
                              output word_t rd, output int lat);
        @(negedge clk);
        data_en    = 1'b1;
        data_addr  = a;
        data_wen   = wen;
        data_wdata = wd;
        lat        = 1;
        do begin
            @(negedge clk);
            lat++;
        end while (stall);
        rd = data_rdata;
        @(negedge clk);
        data_en  = 1'b0;
        data_wen = '0;
    endtask

    task automatic load_word(input addr_t a, output int lat);
        word_t rd;
        run_access(a, '0, '0, rd, lat);
        compare("data_rdata", rd, shadow_word(a));
    endtask

    task automatic store_word(input addr_t a, input wstrb_t wen, input word_t wd, output int lat);
        word_t rd;
        run_access(a, wen, wd, rd, lat);
        update_shadow(a, wen, wd);
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        compare("stall", 32'(stall), 0);
        compare("arvalid", 32'(arvalid), 0);
        compare("awvalid", 32'(awvalid), 0);
        compare("wvalid", 32'(wvalid), 0);
        compare("rready", 32'(rready), 0);
        compare("bready", 32'(bready), 0);
    endtask

    task automatic cold_then_warm_load();
        addr_t a;
        int    lat;
        int    ar_before;
        a         = 32'h0001_2344;
        ar_before = ar_count;
        load_word(a, lat);
        compare("read bursts", ar_count - ar_before, 1);
        compare("araddr", last_araddr, {a[31:5], 5'b0});
        compare("cold load stalled", 32'(lat > 2), 1);
        load_word(a + 8, lat);   // same line
        compare("latency", lat, 2);
    endtask

    task automatic partial_store_merge();
        int lat;
        store_word(32'h0001_2350, 4'b0110, 32'hdead_beef, lat);
        compare("store latency", lat, 2);
        load_word(32'h0001_2350, lat);
    endtask

    task automatic plru_eviction();
        addr_t line_a, line_b, line_c, line_d, line_e;
        int    lat;
        int    aw_before;
        line_a = 32'h0010_00a0;   // all in set 5
        line_b = 32'h0010_10a0;
        line_c = 32'h0010_20a0;
        line_d = 32'h0010_30a0;
        line_e = 32'h0010_40a0;
        load_word(line_a, lat);
        load_word(line_b, lat);
        load_word(line_c, lat);
        load_word(line_d, lat);
        store_word(line_b + 12, 4'hf, 32'hcafe_0b0b, lat);
        // fills land in ways 0, 2, 1, 3; touching D then A leaves the tree on way 2
        load_word(line_d, lat);
        load_word(line_a, lat);
        aw_before = aw_count;
        wbeats.delete();
        load_word(line_e, lat);
        compare("write bursts", aw_count - aw_before, 1);
        compare("awaddr", last_awaddr, line_b);
        compare("write beats", wbeats.size(), LINE_WORDS);
        foreach (wbeats[k])
            compare("wdata", wbeats[k], shadow_word(line_b + addr_t'(4 * k)));
        load_word(line_a, lat);
        compare("latency", lat, 2);
        load_word(line_b + 12, lat);
    endtask

    task automatic random_traffic();
        addr_t  a;
        wstrb_t wen;
        word_t  wd;
        int     lat;
        for (int n = 0; n < 200; n++) begin
            rng = lcg_step(rng);
            // 8 tags over sets 9 and 10
            a   = {20'h00200 + 20'(rng[26:24]), 7'd9 + 7'(rng[27]), rng[30:28], 2'b00};
            wen = rng[19] ? rng[23:20] : 4'h0;
            rng = lcg_step(rng);
            wd  = rng;
            if (wen != 4'h0)
                store_word(a, wen, wd, lat);
            else
                load_word(a, lat);
        end
    endtask

    // bus monitor for burst counts and write beats
    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_count++;
            last_araddr = araddr;
        end
        if (awvalid && awready) begin
            aw_count++;
            last_awaddr = awaddr;
            w_pos       = 0;
        end
        if (wvalid && wready) begin
            wbeats.push_back(wdata);
            compare("wlast", 32'(wlast), 32'(w_pos == BURST_LEN));
            w_pos++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        data_en    = 1'b0;
        data_addr  = '0;
        data_wen   = '0;
        data_wdata = '0;
        rng        = 32'h84a4_717e;
        wait (rst === 1'b0);
        idle_after_reset();
        cold_then_warm_load();
        partial_store_merge();
        plru_eviction();
        random_traffic();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* src.f */
src/dcache_pkg.sv
src/dcache_data_store.sv
src/dcache_line_state.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/tb_clock.sv
verif/axi_mem_model.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
